// File: common/feedback_pkg.sv
/*
 * Shared widths, constants and types of the ALU feedback path
 * S is a single word per thread at one fixed write address
 */

package feedback_pkg;

    // ----------------------------------------------------------------------------
    // Word and address sizes

    // ALU result width, also the width of R and S
    localparam int word_width = 32;

    // Write address carried with the second result
    localparam int addr_width = 10;

    // ----------------------------------------------------------------------------
    // Multithreading

    // Hardware threads sharing the pipeline round robin
    localparam int thread_count = 4;
    localparam int thread_width = 2;

    // ----------------------------------------------------------------------------
    // S storage and pipeline alignment

    // Only this address writes S, range of one word
    localparam logic [addr_width-1:0] s_write_addr = 10'h3F0;

    // Input ports to stage 1
    localparam int input_sync_depth = 2;

    // Stage 0 to output ports
    localparam int output_sync_depth = 1;

    // ----------------------------------------------------------------------------
    // Types

    typedef logic [word_width-1:0]   word_t;
    typedef logic [addr_width-1:0]   addr_t;
    typedef logic [thread_width-1:0] thread_t;

endpackage

// File: logic/delay_line.sv
/*
 * Fixed delay of depth cycles, all stages cleared by rst
 * depth 0 is a plain wire from in to out
 */

module delay_line #(
    parameter int depth = 1,
    parameter int width = 1
) (
    input  logic             clock,
    input  logic             rst,
    input  logic [width-1:0] in,
    output logic [width-1:0] out
);

    generate
        if (depth == 0) begin : g_pass
            // No stages, straight through
            assign out = in;
        end else begin : g_chain
            logic [width-1:0] stage [depth];

            always_ff @(posedge clock) begin
                if (rst) begin
                    for (int i = 0; i < depth; i++) begin
                        stage[i] <= '0;
                    end
                end else begin
                    stage[0] <= in;
                    // Shift toward the output end
                    for (int i = 1; i < depth; i++) begin
                        stage[i] <= stage[i-1];
                    end
                end
            end

            // Oldest stage drives the output
            assign out = stage[depth-1];
        end
    endgenerate

endmodule

// File: logic/thread_number.sv
/*
 * Round-robin thread counter, starts at 0 and steps every cycle
 * next_thread is combinational from current_thread
 */

module thread_number (
    input  logic                  clock,
    input  logic                  rst,
    output feedback_pkg::thread_t current_thread,
    output feedback_pkg::thread_t next_thread
);

    // Highest thread number, wrap point
    localparam feedback_pkg::thread_t last_thread =
        feedback_pkg::thread_t'(feedback_pkg::thread_count - 1);

    // Next value, wraps at thread_count
    always_comb begin
        if (current_thread == last_thread) begin
            next_thread = '0;
        end else begin
            next_thread = current_thread + 1'b1;
        end
    end

    // Counter register
    always_ff @(posedge clock) begin
        if (rst) begin
            current_thread <= '0;
        end else begin
            current_thread <= next_thread;
        end
    end

endmodule

// File: logic/ram_sdp.sv
/*
 * Simple dual-port RAM, one word per thread, registered read
 * Same-edge read and write of one entry returns the old word
 */

module ram_sdp (
    input  logic                  clock,

    // Write port
    input  logic                  wren,
    input  feedback_pkg::thread_t write_addr,
    input  feedback_pkg::word_t   write_data,

    // Read port, always enabled
    input  feedback_pkg::thread_t read_addr,
    output feedback_pkg::word_t   read_data
);

    // ----------------------------------------------------------------------------
    // Storage

    // One entry per hardware thread
    feedback_pkg::word_t mem [feedback_pkg::thread_count];

    // ----------------------------------------------------------------------------
    // Write port

    always_ff @(posedge clock) begin
        if (wren) begin
            mem[write_addr] <= write_data;
        end
    end

    // ----------------------------------------------------------------------------
    // Read port

    // Samples the array before this edge's write lands
    always_ff @(posedge clock) begin
        read_data <= mem[read_addr];
    end

endmodule

// File: feedback_path/alu_feedback_path.sv
/*
 * Returns R, its zero and negative flags, and the per-thread S, 4 edges after the slot
 * S reads 0 for a thread until its first write; no stall or back-pressure
 */

module alu_feedback_path (
    input  logic                clock,
    input  logic                rst,

    // From the forward path
    input  feedback_pkg::word_t ra,
    input  feedback_pkg::word_t rb,
    input  feedback_pkg::addr_t db,
    input  logic                io_ready,
    input  logic                cancel,

    // Back to the forward path
    output feedback_pkg::word_t r,
    output logic                r_zero,
    output logic                r_negative,
    output feedback_pkg::word_t s
);

    // Bundle widths of the two alignment delays
    localparam int in_sync_width  = 2 + feedback_pkg::addr_width + 2 * feedback_pkg::word_width;
    localparam int out_sync_width = 2 + 2 * feedback_pkg::word_width;

    // ----------------------------------------------------------------------------
    // Input alignment to stage 1

    logic                io_ready_stage1;
    logic                cancel_stage1;
    feedback_pkg::addr_t db_stage1;
    feedback_pkg::word_t ra_stage1;
    feedback_pkg::word_t rb_stage1;

    // Cleared stages carry io_ready low, so refill writes nothing
    delay_line #(
        .depth (feedback_pkg::input_sync_depth),
        .width (in_sync_width)
    ) input_sync (
        .clock (clock),
        .rst   (rst),
        .in    ({io_ready, cancel, db, ra, rb}),
        .out   ({io_ready_stage1, cancel_stage1, db_stage1, ra_stage1, rb_stage1})
    );

    // ----------------------------------------------------------------------------
    // Stage 1 qualification

    logic not_nop;
    logic s_addr_hit;
    logic s_wren;

    // No-op when I/O not ready or cancelled
    assign not_nop    = io_ready_stage1 && !cancel_stage1;
    assign s_addr_hit = (db_stage1 == feedback_pkg::s_write_addr);
    assign s_wren     = not_nop && s_addr_hit;

    // ----------------------------------------------------------------------------
    // S storage

    feedback_pkg::thread_t                 s_thread_write;
    feedback_pkg::thread_t                 s_thread_read;
    feedback_pkg::word_t                   s_read;
    logic [feedback_pkg::thread_count-1:0] s_written;
    logic                                  s_read_valid;

    // current_thread owns the stage-1 slot
    thread_number s_thread (
        .clock          (clock),
        .rst            (rst),
        .current_thread (s_thread_write),
        .next_thread    (s_thread_read)
    );

    // Read one cycle ahead, data lands while the slot sits in stage 1
    ram_sdp s_register (
        .clock      (clock),
        .wren       (s_wren),
        .write_addr (s_thread_write),
        .write_data (rb_stage1),
        .read_addr  (s_thread_read),
        .read_data  (s_read)
    );

    // Per-thread written marks, mask unwritten RAM words to 0
    always_ff @(posedge clock) begin
        if (rst) begin
            s_written    <= '0;
            s_read_valid <= 1'b0;
        end else begin
            if (s_wren) begin
                s_written[s_thread_write] <= 1'b1;
            end
            // Tracks the RAM read of the same edge
            s_read_valid <= s_written[s_thread_read];
        end
    end

    // ----------------------------------------------------------------------------
    // Stage 0 registers

    feedback_pkg::word_t ra_stage0;
    logic                r_zero_stage0;
    logic                r_negative_stage0;
    feedback_pkg::word_t s_stage0;

    always_ff @(posedge clock) begin
        if (rst) begin
            ra_stage0         <= '0;
            r_zero_stage0     <= 1'b0;
            r_negative_stage0 <= 1'b0;
            s_stage0          <= '0;
        end else begin
            ra_stage0         <= ra_stage1;
            r_zero_stage0     <= (ra_stage1 == '0);
            // Sign bit of two's complement word
            r_negative_stage0 <= ra_stage1[feedback_pkg::word_width-1];
            s_stage0          <= s_read_valid ? s_read : '0;
        end
    end

    // ----------------------------------------------------------------------------
    // Output alignment

    delay_line #(
        .depth (feedback_pkg::output_sync_depth),
        .width (out_sync_width)
    ) output_sync (
        .clock (clock),
        .rst   (rst),
        .in    ({ra_stage0, r_zero_stage0, r_negative_stage0, s_stage0}),
        .out   ({r, r_zero, r_negative, s})
    );

endmodule

// File: verif/tb_clock_gen.sv
/*
 * Testbench clock of 100 ns period, rst held high for the first 4 rising edges
 */

module tb_clock_gen (
    output logic clock,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int reset_cycles = 4;

    // Free-running clock, low at time 0
    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Release right after the last reset edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        rst <= 1'b0;
    end

endmodule

// File: verif/alu_feedback_path_asserts.sv
/*
 * Flag and S write-enable properties, checked against the top-level inputs
 * Checks start once the first slot after reset can reach the point checked
 */

module alu_feedback_path_asserts (
    input logic                clock,
    input logic                rst,
    input feedback_pkg::word_t ra,
    input feedback_pkg::addr_t db,
    input logic                io_ready,
    input logic                cancel,
    input feedback_pkg::word_t r,
    input logic                r_zero,
    input logic                r_negative,
    input logic                s_wren
);

    timeunit 1ns;
    timeprecision 100ps;

    // Failure counts, read by the testbench for its summary
    int zero_flag_failures      = 0;
    int negative_flag_failures  = 0;
    int write_enable_failures   = 0;

    // Edges since reset, saturates at 4
    logic [2:0] settle_count;

    always_ff @(posedge clock) begin
        if (rst) begin
            settle_count <= '0;
        end else if (settle_count != 3'd4) begin
            settle_count <= settle_count + 1'b1;
        end
    end

    // Zero flag of the slot presented 4 edges earlier
    zero_flag_matches: assert property (@(posedge clock) disable iff (rst)
        (settle_count == 3'd4) |-> (r_zero == ($past(ra, 4) == '0)))
    else begin
        zero_flag_failures++;
        $error("r_zero does not match r");
    end

    // Sign bit of the slot presented 4 edges earlier
    negative_flag_matches: assert property (@(posedge clock) disable iff (rst)
        (settle_count == 3'd4) |->
            (r_negative == $past(ra[feedback_pkg::word_width-1], 4)))
    else begin
        negative_flag_failures++;
        $error("r_negative does not match the sign bit of r");
    end

    // No S write from a no-op slot or another address, slot presented 2 edges earlier
    write_only_when_active: assert property (@(posedge clock) disable iff (rst)
        ((settle_count >= 3'd2) && s_wren) |->
            ($past(io_ready, 2) && !$past(cancel, 2)
             && ($past(db, 2) == feedback_pkg::s_write_addr)))
    else begin
        write_enable_failures++;
        $error("S written by a no-op slot");
    end

endmodule

// File: verif/alu_feedback_path_tb.sv
/*
 * Directed testbench, one slot driven per falling edge, outputs checked 4 cycles later
 * Expected values come from a per-thread S model and the R flag rules
 */

module alu_feedback_path_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // Slot to output, in falling edges
    localparam int latency       = 4;
    localparam int reset_timeout = 20;

    typedef struct packed {
        logic signed [31:0]  slot;
        feedback_pkg::word_t r;
        logic                r_zero;
        logic                r_negative;
        feedback_pkg::word_t s;
    } expected_t;

    logic                clock;
    logic                rst;
    feedback_pkg::word_t ra;
    feedback_pkg::word_t rb;
    feedback_pkg::addr_t db;
    logic                io_ready;
    logic                cancel;
    feedback_pkg::word_t r;
    logic                r_zero;
    logic                r_negative;
    feedback_pkg::word_t s;

    // Negative slot numbers mark pipeline fill after reset
    expected_t           expected_q [$];
    feedback_pkg::word_t s_model [feedback_pkg::thread_count];
    int                  slot_count  = 0;
    int                  check_count = 0;
    int                  error_count = 0;

    // ------------------------------------------------------------------------
    // Clock, DUT and assertions

    tb_clock_gen clock_gen (
        .clock (clock),
        .rst   (rst)
    );

    alu_feedback_path i_alu_feedback_path (
        .clock      (clock),
        .rst        (rst),
        .ra         (ra),
        .rb         (rb),
        .db         (db),
        .io_ready   (io_ready),
        .cancel     (cancel),
        .r          (r),
        .r_zero     (r_zero),
        .r_negative (r_negative),
        .s          (s)
    );

    bind alu_feedback_path alu_feedback_path_asserts i_alu_feedback_path_asserts (
        .clock      (clock),
        .rst        (rst),
        .ra         (ra),
        .db         (db),
        .io_ready   (io_ready),
        .cancel     (cancel),
        .r          (r),
        .r_zero     (r_zero),
        .r_negative (r_negative),
        .s_wren     (s_wren)
    );

    // ------------------------------------------------------------------------
    // Checking and slot driving

    task automatic check_value(input string what, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // Pops the oldest expected slot and compares it with the outputs
    task automatic compare_outputs();
        expected_t exp_out;
        if (expected_q.size() == 0) begin
            error_count++;
            $display("No expected slot was queued when the outputs were compared");
        end else begin
            exp_out = expected_q.pop_front();
            check_value($sformatf("slot %0d r", exp_out.slot), r, exp_out.r);
            check_value($sformatf("slot %0d r_zero", exp_out.slot), r_zero, exp_out.r_zero);
            check_value($sformatf("slot %0d r_negative", exp_out.slot), r_negative,
                        exp_out.r_negative);
            check_value($sformatf("slot %0d s", exp_out.slot), s, exp_out.s);
        end
    endtask

    // Slot k belongs to thread (k+2) mod thread_count
    function automatic feedback_pkg::thread_t slot_thread(input int slot);
        return feedback_pkg::thread_t'((slot + 2) % feedback_pkg::thread_count);
    endfunction

    // Called on a falling edge, returns on the next one
    task automatic drive_slot(input feedback_pkg::word_t ra_value,
                              input feedback_pkg::word_t rb_value,
                              input feedback_pkg::addr_t db_value,
                              input logic ready_value, input logic cancel_value);
        feedback_pkg::thread_t thread;
        expected_t             exp_out;
        compare_outputs();
        ra       = ra_value;
        rb       = rb_value;
        db       = db_value;
        io_ready = ready_value;
        cancel   = cancel_value;
        thread   = slot_thread(slot_count);
        exp_out.slot       = slot_count;
        exp_out.r          = ra_value;
        exp_out.r_zero     = (ra_value == '0);
        exp_out.r_negative = ra_value[feedback_pkg::word_width-1];
        // S from the thread's earlier turns only
        exp_out.s          = s_model[thread];
        if (ready_value && !cancel_value && db_value == feedback_pkg::s_write_addr) begin
            s_model[thread] = rb_value;
        end
        expected_q.push_back(exp_out);
        slot_count++;
        @(negedge clock);
    endtask

    // Idle slots until every earlier slot has been compared
    task automatic flush_pipeline();
        for (int i = 0; i < latency; i++) begin
            drive_slot('0, '0, '0, 1'b0, 1'b0);
        end
    endtask

    // ------------------------------------------------------------------------
    // Directed tests

    task automatic reset_test(output logic released);
        int        cycles;
        expected_t fill;
        released = 1'b0;
        cycles   = 0;
        while (!released && cycles < reset_timeout) begin
            @(negedge clock);
            cycles++;
            if (rst) begin
                check_value("r during reset", r, '0);
                check_value("r_zero during reset", r_zero, 1'b0);
                check_value("r_negative during reset", r_negative, 1'b0);
                check_value("s during reset", s, '0);
            end else begin
                released = 1'b1;
            end
        end
        if (released) begin
            // S of a thread reads 0 until first written
            for (int t = 0; t < feedback_pkg::thread_count; t++) begin
                s_model[t] = '0;
            end
            // Cleared output and stage-0 registers, then cleared input stages as ra 0 bubbles
            for (int i = 0; i < latency; i++) begin
                fill.slot       = i - latency;
                fill.r          = '0;
                fill.r_zero     = (i > feedback_pkg::output_sync_depth);
                fill.r_negative = 1'b0;
                fill.s          = '0;
                expected_q.push_back(fill);
            end
        end
    endtask

    // Back to back, so the pipeline is full
    task automatic pass_through_test();
        for (int i = 0; i < 16; i++) begin
            drive_slot($urandom, $urandom, feedback_pkg::addr_t'($urandom), 1'b0, 1'b0);
        end
        flush_pipeline();
    endtask

    task automatic flags_test();
        feedback_pkg::word_t values [4];
        values = '{32'h0000_0000, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0001};
        for (int i = 0; i < 4; i++) begin
            drive_slot(values[i], $urandom, '0, 1'b1, 1'b0);
        end
        // Random positives, never zero
        for (int i = 0; i < 8; i++) begin
            drive_slot(($urandom & 32'h7FFF_FFFF) | 32'h1, $urandom, '0, 1'b1, 1'b0);
        end
        flush_pipeline();
    endtask

    // One write per thread, then a read turn with no writes
    task automatic s_storage_test();
        feedback_pkg::thread_t thread;
        for (int i = 0; i < feedback_pkg::thread_count; i++) begin
            thread = slot_thread(slot_count);
            drive_slot($urandom, {6'h28, thread, 24'($urandom)}, feedback_pkg::s_write_addr,
                       1'b1, 1'b0);
        end
        for (int i = 0; i < feedback_pkg::thread_count; i++) begin
            drive_slot($urandom, $urandom, feedback_pkg::s_write_addr + 1'b1, 1'b1, 1'b0);
        end
        flush_pipeline();
    endtask

    // Cancelled, not ready and wrong-address turns, then a read turn
    task automatic qualification_test();
        for (int turn = 0; turn < 4; turn++) begin
            for (int i = 0; i < feedback_pkg::thread_count; i++) begin
                case (turn)
                    0: drive_slot($urandom, $urandom, feedback_pkg::s_write_addr, 1'b1, 1'b1);
                    1: drive_slot($urandom, $urandom, feedback_pkg::s_write_addr, 1'b0, 1'b0);
                    2: drive_slot($urandom, $urandom,
                                  feedback_pkg::s_write_addr ^ feedback_pkg::addr_t'(i + 1),
                                  1'b1, 1'b0);
                    default: drive_slot($urandom, $urandom, '0, 1'b0, 1'b0);
                endcase
            end
        end
        flush_pipeline();
    endtask

    task automatic random_mix_test();
        feedback_pkg::word_t ra_value;
        feedback_pkg::addr_t db_value;
        logic                ready_value;
        logic                cancel_value;
        for (int i = 0; i < 200; i++) begin
            ra_value     = ($urandom % 16 == 0) ? '0 : $urandom;
            // Mostly the S address, so writes are frequent
            db_value     = ($urandom % 4 != 0) ? feedback_pkg::s_write_addr
                                               : feedback_pkg::addr_t'($urandom);
            ready_value  = ($urandom % 8) != 0;
            cancel_value = ($urandom % 8) == 0;
            drive_slot(ra_value, $urandom, db_value, ready_value, cancel_value);
        end
        flush_pipeline();
    endtask

    // ------------------------------------------------------------------------
    // Test sequence

    initial begin
        logic        released;
        int unsigned seed_result;
        int          assert_failures;
        ra       = '0;
        rb       = '0;
        db       = '0;
        io_ready = 1'b0;
        cancel   = 1'b0;
        seed_result = $urandom(32'h978);
        reset_test(released);
        if (!released) begin
            $display("Reset was not released within %0d clock cycles", reset_timeout);
            $display("Test failures found");
            $finish;
        end else begin
            pass_through_test();
            flags_test();
            s_storage_test();
            qualification_test();
            random_mix_test();
            assert_failures =
                i_alu_feedback_path.i_alu_feedback_path_asserts.zero_flag_failures
                + i_alu_feedback_path.i_alu_feedback_path_asserts.negative_flag_failures
                + i_alu_feedback_path.i_alu_feedback_path_asserts.write_enable_failures;
            $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                     check_count, error_count, assert_failures);
            if (error_count == 0 && assert_failures == 0) begin
                $display("All tests passed!");
            end else begin
                $display("Test failures found");
            end
            $finish;
        end
    end

endmodule

// File: alu_feedback_path.f
common/feedback_pkg.sv
logic/delay_line.sv
logic/thread_number.sv
logic/ram_sdp.sv
feedback_path/alu_feedback_path.sv
verif/tb_clock_gen.sv
verif/alu_feedback_path_asserts.sv
verif/alu_feedback_path_tb.sv
